// ==== verilog/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address width of the memory port
`define MEM_ADDR_BITS 32

// one cache line of eight 32-bit words
`define MEM_LINE_BITS 256

// one burst beat of two words
`define MEM_BEAT_BITS 64

// beats per line with the lowest beat moving first
`define MEM_BEATS 4

`endif

// ==== verilog/mem_types_pkg.sv ====
`default_nettype none

`include "mem_defs.svh"

package mem_types_pkg;

    // line address as issued by either cache
    typedef logic [`MEM_ADDR_BITS-1:0] addr_t;

    // full cache line between caches and datapath
    typedef logic [`MEM_LINE_BITS-1:0] line_t;

    // single beat on the memory bus
    typedef logic [`MEM_BEAT_BITS-1:0] beat_t;

endpackage

`default_nettype wire

// ==== verilog/arb_pkg.sv ====
`default_nettype none

package arb_pkg;

    // arbiter FSM states
    // idle waits for a request, busy runs the burst,
    // done is the single cycle of the cache resp pulse
    typedef enum logic [1:0] {
        idle = 2'd0,
        busy = 2'd1,
        done = 2'd2
    } arb_state_t;

    // owner of the shared memory port
    typedef enum logic {
        instr = 1'b0,
        data  = 1'b1
    } grant_t;

endpackage

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module mem_arbiter (
    input  wire             clk,
    input  wire             rst,
    input  wire             instr_read,
    input  wire             instr_write,
    input  wire             data_read,
    input  wire             data_write,
    input  wire             mem_resp,
    output arb_pkg::grant_t grant,
    output logic            load,
    output logic            beat_advance,
    output logic            mem_read,
    output logic            mem_write,
    output logic            instr_resp,
    output logic            data_resp
);

    // index of the final beat in a burst
    localparam logic [1:0] BEAT_LAST = 2'(`MEM_BEATS - 1);

    arb_pkg::arb_state_t state;
    arb_pkg::arb_state_t state_next;
    // owner of the current burst and afterwards the cache served last
    arb_pkg::grant_t     owner;
    arb_pkg::grant_t     pick;
    logic [1:0]          beat_cnt;
    logic                instr_req;
    logic                data_req;
    logic                pick_write;

    assign instr_req = instr_read || instr_write;
    assign data_req  = data_read || data_write;

    // when both wait the cache not served last goes next
    always_comb begin
        if (instr_req && data_req) begin
            pick = (owner == arb_pkg::instr) ? arb_pkg::data : arb_pkg::instr;
        end else if (data_req) begin
            pick = arb_pkg::data;
        end else begin
            pick = arb_pkg::instr;
        end
    end

    assign pick_write = (pick == arb_pkg::instr) ? instr_write : data_write;

    // grant is the pending choice while idle so the serializer can latch it
    assign load         = (state == arb_pkg::idle) && (instr_req || data_req);
    assign grant        = (state == arb_pkg::idle) ? pick : owner;
    assign beat_advance = (state == arb_pkg::busy) && mem_resp;

    // resp only reaches the owner
    assign instr_resp = (state == arb_pkg::done) && (owner == arb_pkg::instr);
    assign data_resp  = (state == arb_pkg::done) && (owner == arb_pkg::data);

    always_comb begin
        state_next = state;
        case (state)
            arb_pkg::idle: begin
                if (load) begin
                    state_next = arb_pkg::busy;
                end
            end
            arb_pkg::busy: begin
                // leave after the fourth beat
                if (beat_advance && (beat_cnt == BEAT_LAST)) begin
                    state_next = arb_pkg::done;
                end
            end
            arb_pkg::done: begin
                state_next = arb_pkg::idle;
            end
            default: begin
                state_next = arb_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= arb_pkg::idle;
            // instr counts as served last, so data wins the first tie
            owner     <= arb_pkg::instr;
            beat_cnt  <= 2'd0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state <= state_next;
            if (load) begin
                owner     <= pick;
                beat_cnt  <= 2'd0;
                mem_read  <= !pick_write;
                mem_write <= pick_write;
            end
            if (beat_advance) begin
                beat_cnt <= beat_cnt + 2'd1;
                // direction drops once the last beat is taken
                if (beat_cnt == BEAT_LAST) begin
                    mem_read  <= 1'b0;
                    mem_write <= 1'b0;
                end
            end
        end
    end

    // one direction at a time and only while a burst runs
    a_mem_dir_excl: assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) |-> (mem_read != mem_write) && (state == arb_pkg::busy))
        else $error("memory direction wrong or outside a burst");

    // a single resp that closes the burst of the cycle before
    a_resp_excl: assert property (@(posedge clk) disable iff (rst)
        (instr_resp || data_resp) |-> !(instr_resp && data_resp) && $past(mem_read || mem_write))
        else $error("resp on both caches or without a finished burst");

    // resp only while the cache still holds its request
    a_instr_resp_req: assert property (@(posedge clk) disable iff (rst)
        instr_resp |-> instr_req)
        else $error("instr_resp without instr request");

    a_data_resp_req: assert property (@(posedge clk) disable iff (rst)
        data_resp |-> data_req)
        else $error("data_resp without data request");

endmodule

`default_nettype wire

// ==== verilog/line_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module line_serializer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load,
    input  wire                  beat_advance,
    input  wire arb_pkg::grant_t grant,
    input  wire mem_types_pkg::addr_t instr_address,
    input  wire mem_types_pkg::addr_t data_address,
    input  wire mem_types_pkg::line_t instr_wdata,
    input  wire mem_types_pkg::line_t data_wdata,
    output mem_types_pkg::addr_t mem_address,
    output mem_types_pkg::beat_t mem_wdata
);

    mem_types_pkg::addr_t addr_q;
    // write line that shifts down as beats leave
    mem_types_pkg::line_t line_q;

    // address stays put for the whole burst
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (load) begin
            addr_q <= (grant == arb_pkg::instr) ? instr_address : data_address;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= (grant == arb_pkg::instr) ? instr_wdata : data_wdata;
        end else if (beat_advance) begin
            // drop the beat just taken and zero fill from the top
            line_q <= {{`MEM_BEAT_BITS{1'b0}},
                       line_q[`MEM_LINE_BITS-1:`MEM_BEAT_BITS]};
        end
    end

    assign mem_address = addr_q;
    // current beat is always the lowest slice
    assign mem_wdata   = line_q[`MEM_BEAT_BITS-1:0];

    // a burst never shifts before its line has been captured
    a_load_no_beat: assert property (@(posedge clk) disable iff (rst)
        load |-> !beat_advance)
        else $error("beat_advance in the load cycle");

endmodule

`default_nettype wire

// ==== verilog/line_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module line_assembler (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        beat_advance,
    input  wire mem_types_pkg::beat_t  mem_rdata,
    output mem_types_pkg::line_t       rdata
);

    mem_types_pkg::line_t line_q;

    // each beat enters at the top and walks down
    // so after four beats the first one sits lowest
    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (beat_advance) begin
            line_q <= {mem_rdata, line_q[`MEM_LINE_BITS-1:`MEM_BEAT_BITS]};
        end
    end

    // held until the next burst and valid during resp
    assign rdata = line_q;

endmodule

`default_nettype wire

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem (
    input  wire                        clk,
    input  wire                        rst,

    // instruction cache
    input  wire mem_types_pkg::addr_t  instr_address,
    output mem_types_pkg::line_t       instr_rdata,
    input  wire mem_types_pkg::line_t  instr_wdata,
    input  wire                        instr_read,
    input  wire                        instr_write,
    output logic                       instr_resp,

    // data cache
    input  wire mem_types_pkg::addr_t  data_address,
    output mem_types_pkg::line_t       data_rdata,
    input  wire mem_types_pkg::line_t  data_wdata,
    input  wire                        data_read,
    input  wire                        data_write,
    output logic                       data_resp,

    // burst memory port
    output mem_types_pkg::addr_t       mem_address,
    output logic                       mem_read,
    output logic                       mem_write,
    output mem_types_pkg::beat_t       mem_wdata,
    input  wire mem_types_pkg::beat_t  mem_rdata,
    input  wire                        mem_resp
);

    arb_pkg::grant_t      grant;
    logic                 load;
    logic                 beat_advance;
    mem_types_pkg::line_t rdata_line;

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst          (rst),
        .instr_read   (instr_read),
        .instr_write  (instr_write),
        .data_read    (data_read),
        .data_write   (data_write),
        .mem_resp     (mem_resp),
        .grant        (grant),
        .load         (load),
        .beat_advance (beat_advance),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .instr_resp   (instr_resp),
        .data_resp    (data_resp)
    );

    line_serializer u_line_serializer (
        .clk           (clk),
        .rst           (rst),
        .load          (load),
        .beat_advance  (beat_advance),
        .grant         (grant),
        .instr_address (instr_address),
        .data_address  (data_address),
        .instr_wdata   (instr_wdata),
        .data_wdata    (data_wdata),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata)
    );

    line_assembler u_line_assembler (
        .clk          (clk),
        .rst          (rst),
        .beat_advance (beat_advance),
        .mem_rdata    (mem_rdata),
        .rdata        (rdata_line)
    );

    // one read line for both caches and only the matching resp qualifies it
    assign instr_rdata = rdata_line;
    assign data_rdata  = rdata_line;

endmodule

`default_nettype wire

// ==== dv/burst_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module burst_mem_model (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mem_types_pkg::addr_t mem_address,
    input  wire                       mem_read,
    input  wire                       mem_write,
    input  wire mem_types_pkg::beat_t mem_wdata,
    output mem_types_pkg::beat_t      mem_rdata,
    output logic                      mem_resp
);

    // only lines that saw a write are stored
    mem_types_pkg::line_t lines [mem_types_pkg::addr_t];
    mem_types_pkg::beat_t rdata_q = '0;
    logic                 resp_q = 1'b0;
    int                   seed = 61;
    // beat index inside the current burst
    int                   beat_idx = 0;
    // idle cycles left before the next beat
    int                   gap = 0;

    assign mem_rdata = rdata_q;
    assign mem_resp  = resp_q;

    // stored line, or the fill pattern of an untouched line
    function automatic mem_types_pkg::line_t line_at(input mem_types_pkg::addr_t a);
        mem_types_pkg::line_t l;
        int w;
        if (lines.exists(a)) begin
            l = lines[a];
        end else begin
            // eight words that each mix the full address with their index
            for (w = 0; w < 8; w++) begin
                l[w*32 +: 32] = a ^ (32'h1111_1111 * 32'(w)) ^ 32'h5a00_00a5;
            end
        end
        return l;
    endfunction

    always @(negedge clk) begin
        mem_types_pkg::line_t l;
        if (rst) begin
            resp_q   <= 1'b0;
            beat_idx = 0;
            gap      = 0;
        end else begin
            // beat shown last cycle was taken at the rising edge
            if (resp_q) begin
                beat_idx = beat_idx + 1;
            end
            if (!mem_read && !mem_write) begin
                beat_idx = 0;
            end
            if ((mem_read || mem_write) && beat_idx < `MEM_BEATS && gap == 0) begin
                l = line_at(mem_address);
                // write beat lands in its slot with the lowest beat first
                if (mem_write) begin
                    l[beat_idx*`MEM_BEAT_BITS +: `MEM_BEAT_BITS] = mem_wdata;
                    lines[mem_address] = l;
                end
                rdata_q <= l[beat_idx*`MEM_BEAT_BITS +: `MEM_BEAT_BITS];
                resp_q  <= 1'b1;
                // 0 to 3 idle cycles before the next beat
                gap = $random(seed) & 3;
            end else begin
                resp_q <= 1'b0;
                if ((mem_read || mem_write) && gap > 0) begin
                    gap = gap - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsystem;

    localparam int REQS = 40;
    // worst case of four beats at four cycles and three cycles of FSM overhead
    // for both caches with margin for reset and idle gaps
    localparam int TIMEOUT_CYCLES = 2 * REQS * (`MEM_BEATS * 4 + 3) + 480;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    mem_types_pkg::addr_t instr_address = '0;
    mem_types_pkg::line_t instr_wdata = '0;
    mem_types_pkg::line_t instr_rdata;
    logic                 instr_read = 1'b0;
    logic                 instr_write = 1'b0;
    logic                 instr_resp;
    mem_types_pkg::addr_t data_address = '0;
    mem_types_pkg::line_t data_wdata = '0;
    mem_types_pkg::line_t data_rdata;
    logic                 data_read = 1'b0;
    logic                 data_write = 1'b0;
    logic                 data_resp;
    mem_types_pkg::addr_t mem_address;
    mem_types_pkg::beat_t mem_wdata;
    mem_types_pkg::beat_t mem_rdata;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_resp;

    // stimulus tables with index 0 for instr and 1 for data
    mem_types_pkg::addr_t req_addr [2][REQS];
    mem_types_pkg::line_t req_line [2][REQS];
    bit                   req_write [2][REQS];
    int                   req_gap [2][REQS];
    int                   seed = 61;

    logic instr_req;
    logic data_req;
    logic dir_active;
    // a request seen while the port is free
    logic start;
    logic rst_q = 1'b0;
    logic active = 1'b0;
    logic both_waiting = 1'b0;
    // cache served last where instr counts after reset
    logic data_last = 1'b0;
    int   beats = 0;
    int   instr_waits = 0;
    int   data_waits = 0;
    int   instr_served = 0;
    int   data_served = 0;
    int   cycles = 0;

    assign instr_req  = instr_read || instr_write;
    assign data_req   = data_read || data_write;
    assign dir_active = mem_read || mem_write;
    assign start      = !active && (instr_req || data_req);

    always #10 clk = ~clk;

    mem_subsystem u_mem_subsystem (
        .clk           (clk),
        .rst           (rst),
        .instr_address (instr_address),
        .instr_rdata   (instr_rdata),
        .instr_wdata   (instr_wdata),
        .instr_read    (instr_read),
        .instr_write   (instr_write),
        .instr_resp    (instr_resp),
        .data_address  (data_address),
        .data_rdata    (data_rdata),
        .data_wdata    (data_wdata),
        .data_read     (data_read),
        .data_write    (data_write),
        .data_resp     (data_resp),
        .mem_address   (mem_address),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .mem_resp      (mem_resp)
    );

    burst_mem_model u_burst_mem_model (
        .clk         (clk),
        .rst         (rst),
        .mem_address (mem_address),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp)
    );

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    // one cache requests, holds until resp and drops a cycle later
    task automatic drive_cache(input int c);
        int i;
        for (i = 0; i < REQS; i++) begin
            repeat (req_gap[c][i]) @(negedge clk);
            if (c == 1) begin
                data_address = req_addr[c][i];
                data_wdata   = req_line[c][i];
                data_write   = req_write[c][i];
                data_read    = !req_write[c][i];
            end else begin
                instr_address = req_addr[c][i];
                instr_wdata   = req_line[c][i];
                instr_write   = req_write[c][i];
                instr_read    = !req_write[c][i];
            end
            do begin
                @(negedge clk);
            end while (!((c == 1) ? data_resp : instr_resp));
            @(negedge clk);
            if (c == 1) begin
                data_read  = 1'b0;
                data_write = 1'b0;
            end else begin
                instr_read  = 1'b0;
                instr_write = 1'b0;
            end
        end
    endtask

    // tracks ownership, beats and waiting time as seen from the ports
    always @(posedge clk) begin
        rst_q  <= rst;
        cycles <= cycles + 1;
        if (rst) begin
            active      <= 1'b0;
            data_last   <= 1'b0;
            beats       <= 0;
            instr_waits <= 0;
            data_waits  <= 0;
        end else begin
            if (start) begin
                active       <= 1'b1;
                both_waiting <= instr_req && data_req;
            end else if (instr_resp || data_resp) begin
                active    <= 1'b0;
                data_last <= data_resp;
            end
            if (!dir_active) begin
                beats <= 0;
            end else if (mem_resp) begin
                beats <= beats + 1;
            end
            // bursts started while a cache holds its request
            if (instr_resp) begin
                instr_waits <= 0;
            end else if (start && instr_req) begin
                instr_waits <= instr_waits + 1;
            end
            if (data_resp) begin
                data_waits <= 0;
            end else if (start && data_req) begin
                data_waits <= data_waits + 1;
            end
            if (instr_resp) begin
                instr_served <= instr_served + 1;
            end
            if (data_resp) begin
                data_served <= data_served + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a request never got its resp", cycles);
            $display("Errors found");
            $fatal(1, "run stopped by the timeout");
        end
    end

    // quiet through the reset cycles and the cycle after
    reset_quiet: assert property (@(posedge clk)
        rst_q |-> !mem_read && !mem_write && !instr_resp && !data_resp)
        else report_error("port active during reset");

    instr_read_line: assert property (@(posedge clk) disable iff (rst)
        instr_resp && instr_read |-> instr_rdata == u_burst_mem_model.line_at(instr_address))
        else report_error($sformatf("instr read line wrong at %h", instr_address));

    data_read_line: assert property (@(posedge clk) disable iff (rst)
        data_resp && data_read |-> data_rdata == u_burst_mem_model.line_at(data_address))
        else report_error($sformatf("data read line wrong at %h", data_address));

    // memory must hold the whole line once resp is out
    instr_line_stored: assert property (@(posedge clk) disable iff (rst)
        instr_resp && instr_write |-> u_burst_mem_model.line_at(instr_address) == instr_wdata)
        else report_error($sformatf("instr write line wrong at %h", instr_address));

    data_line_stored: assert property (@(posedge clk) disable iff (rst)
        data_resp && data_write |-> u_burst_mem_model.line_at(data_address) == data_wdata)
        else report_error($sformatf("data write line wrong at %h", data_address));

    exclusive_port: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write) && !(instr_resp && data_resp))
        else report_error("both directions or both resps high");

    resp_owned: assert property (@(posedge clk) disable iff (rst)
        !(instr_resp && !instr_req) && !(data_resp && !data_req))
        else report_error("resp without an open request");

    resp_single: assert property (@(posedge clk) disable iff (rst)
        instr_resp || data_resp |=> !instr_resp && !data_resp)
        else report_error("resp longer than one cycle");

    // tie goes to the cache not served last
    tie_alternates: assert property (@(posedge clk) disable iff (rst)
        (instr_resp || data_resp) && both_waiting |-> data_resp != data_last)
        else report_error("tie served the same cache twice");

    wait_bounded: assert property (@(posedge clk) disable iff (rst)
        instr_waits <= 2 && data_waits <= 2)
        else report_error("request waited longer than two bursts");

    grant_next_edge: assert property (@(posedge clk) disable iff (rst)
        start |=> dir_active)
        else report_error("request on a free port not granted at the next edge");

    address_steady: assert property (@(posedge clk) disable iff (rst)
        dir_active && $past(dir_active) |-> mem_address == $past(mem_address))
        else report_error("mem_address moved during a burst");

    // direction drops right after the fourth beat
    burst_closes: assert property (@(posedge clk) disable iff (rst)
        dir_active && mem_resp && beats == `MEM_BEATS - 1 |=> !dir_active)
        else report_error("burst kept going after the fourth beat");

    initial begin
        int c;
        int i;
        int w;
        for (c = 0; c < 2; c++) begin
            for (i = 0; i < REQS; i++) begin
                req_write[c][i] = ($random(seed) & 1) != 0;
                // eight lines shared by both caches, so reads hit writes
                req_addr[c][i]  = 32'h0000_4000 + (($random(seed) & 7) << 5);
                for (w = 0; w < 8; w++) begin
                    req_line[c][i][w*32 +: 32] = $random(seed);
                end
                // first requests start together
                req_gap[c][i] = (i == 0) ? 0 : ($random(seed) & 3);
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        fork
            drive_cache(0);
            drive_cache(1);
        join
        repeat (3) @(negedge clk);
        if (instr_served != REQS || data_served != REQS) begin
            report_error($sformatf("resp count instr %0d data %0d, expected %0d each",
                                   instr_served, data_served, REQS));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/arb_pkg.sv
verilog/mem_arbiter.sv
verilog/line_serializer.sv
verilog/line_assembler.sv
verilog/mem_subsystem.sv
dv/burst_mem_model.sv
dv/tb_mem_subsystem.sv

// ==== Makefile ====
TOP = tb_mem_subsystem

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/10ps -f build.f \
		--top-module $(TOP) -Mdir obj_dir -o sim
	-./obj_dir/sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f build.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
